// File: dcache_pkg.sv
package dcache_pkg;

    // cache geometry
    localparam int NUM_WAYS       = 2;
    localparam int NUM_SETS       = 64;
    localparam int WORDS_PER_LINE = 16;
    localparam int BYTES_PER_WORD = 4;
    localparam int BYTE_BITS      = 8;

    // derived field widths
    localparam int WORD_BITS   = BYTES_PER_WORD * BYTE_BITS;
    localparam int WAY_BITS    = $clog2(NUM_WAYS);
    localparam int INDEX_BITS  = $clog2(NUM_SETS);
    localparam int OFFSET_BITS = $clog2(WORDS_PER_LINE);
    localparam int ALIGN_BITS  = $clog2(BYTES_PER_WORD);
    localparam int TAG_BITS    = 32 - INDEX_BITS - OFFSET_BITS - ALIGN_BITS;

    typedef logic [WORD_BITS-1:0] word_t;

    typedef logic [BYTES_PER_WORD-1:0] strobe_t;

    typedef logic [TAG_BITS-1:0] tag_t;

    typedef logic [INDEX_BITS-1:0] index_t;

    typedef logic [OFFSET_BITS-1:0] offset_t;

    typedef logic [WAY_BITS-1:0] way_t;

    // byte address as seen by the cache
    typedef struct packed {
        tag_t                  tag;
        index_t                index;
        offset_t               offset;
        logic [ALIGN_BITS-1:0] align;
    } addr_t;

endpackage

// File: cache_ifs.sv
`timescale 1ns/100ps

// shared lookup and write lines from the controller, results back per way
interface way_if;
    import dcache_pkg::*;

    index_t  index;
    offset_t offset;
    tag_t    tag;

    logic    wr_en;
    way_t    wr_way;
    strobe_t wr_strobe;
    word_t   wr_data;

    logic    fill_en;
    way_t    fill_way;

    // one element per way
    logic    hit [NUM_WAYS];
    logic    victim_valid [NUM_WAYS];
    logic    victim_dirty [NUM_WAYS];
    tag_t    victim_tag [NUM_WAYS];
    word_t   rd_data [NUM_WAYS];

    modport ctrl (
        output index, offset, tag, wr_en, wr_way, wr_strobe, wr_data, fill_en, fill_way
    );

    modport way (
        input  index, offset, tag, wr_en, wr_way, wr_strobe, wr_data, fill_en, fill_way,
        output hit, victim_valid, victim_dirty, victim_tag, rd_data
    );

    modport sel (
        input hit, victim_valid, victim_dirty, victim_tag, rd_data
    );
endinterface

// combined lookup result between way_select and the controller
interface lookup_if;
    import dcache_pkg::*;

    logic any_hit;
    way_t hit_way;
    logic victim_valid;
    logic victim_dirty;
    tag_t victim_tag;
    way_t victim_way;
    way_t rd_way;

    modport res (
        output any_hit, hit_way, victim_valid, victim_dirty, victim_tag,
        input  victim_way, rd_way
    );

    modport ctrl (
        input  any_hit, hit_way, victim_valid, victim_dirty, victim_tag,
        output victim_way, rd_way
    );
endinterface

// File: cache_way.sv
`timescale 1ns/100ps

module cache_way #(
    parameter int WAY_ID = 0
) (
    input logic clk,
    input logic resetn,
    way_if.way  bus
);
    import dcache_pkg::*;

    logic [NUM_SETS-1:0] valid;
    logic [NUM_SETS-1:0] dirty;
    tag_t                tag_ram [NUM_SETS];
    word_t               data_ram [NUM_SETS*WORDS_PER_LINE];
    word_t               rd_q;

    logic                             wr_sel;
    logic                             fill_sel;
    logic [INDEX_BITS+OFFSET_BITS-1:0] word_addr;

    assign word_addr = {bus.index, bus.offset};
    assign wr_sel    = bus.wr_en && (bus.wr_way == way_t'(WAY_ID));
    assign fill_sel  = bus.fill_en && (bus.fill_way == way_t'(WAY_ID));

    // lookup is combinational on index and tag
    assign bus.hit[WAY_ID]          = valid[bus.index] && (tag_ram[bus.index] == bus.tag);
    assign bus.victim_valid[WAY_ID] = valid[bus.index];
    assign bus.victim_dirty[WAY_ID] = dirty[bus.index];
    assign bus.victim_tag[WAY_ID]   = tag_ram[bus.index];
    assign bus.rd_data[WAY_ID]      = rd_q;

    always_ff @(posedge clk) begin
        if (resetn) begin
            valid <= '0;
            dirty <= '0;
        end else begin
            // fill wins over the last refill beat's write
            if (fill_sel) begin
                valid[bus.index] <= 1'b1;
                dirty[bus.index] <= 1'b0;
            end else if (wr_sel) begin
                dirty[bus.index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_sel) begin
            tag_ram[bus.index] <= bus.tag;
        end
    end

    // byte lanes, read returns the old word on a same-cycle write
    always_ff @(posedge clk) begin
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (wr_sel && bus.wr_strobe[b]) begin
                data_ram[word_addr][b*BYTE_BITS +: BYTE_BITS] <=
                    bus.wr_data[b*BYTE_BITS +: BYTE_BITS];
            end
        end
        rd_q <= data_ram[word_addr];
    end

endmodule

// File: way_select.sv
`timescale 1ns/100ps

module way_select (
    input  logic              clk,
    input  logic              resetn,
    way_if.sel                ways,
    lookup_if.res             lk,
    output dcache_pkg::word_t rd_data
);
    import dcache_pkg::*;

    way_t rd_way_q;

    // at most one way hits for a given tag
    always_comb begin
        lk.any_hit = 1'b0;
        lk.hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (ways.hit[w]) begin
                lk.any_hit = 1'b1;
                lk.hit_way = way_t'(w);
            end
        end
    end

    // metadata of the way picked for replacement
    assign lk.victim_valid = ways.victim_valid[lk.victim_way];
    assign lk.victim_dirty = ways.victim_dirty[lk.victim_way];
    assign lk.victim_tag   = ways.victim_tag[lk.victim_way];

    // ways read one cycle late, so the select follows
    always_ff @(posedge clk) begin
        if (resetn) begin
            rd_way_q <= '0;
        end else begin
            rd_way_q <= lk.rd_way;
        end
    end

    assign rd_data = ways.rd_data[rd_way_q];

endmodule

// File: cache_ctrl.sv
`timescale 1ns/100ps

module cache_ctrl (
    input  logic                clk,
    input  logic                resetn,
    input  logic                dreq_valid,
    input  dcache_pkg::addr_t   dreq_addr,
    input  dcache_pkg::strobe_t dreq_strobe,
    input  dcache_pkg::word_t   dreq_data,
    output logic                dresp_addr_ok,
    output logic                dresp_data_ok,
    output logic                creq_valid,
    output logic                creq_is_write,
    output dcache_pkg::addr_t   creq_addr,
    output dcache_pkg::word_t   creq_data,
    input  logic                cresp_ready,
    input  logic                cresp_last,
    input  dcache_pkg::word_t   cresp_data,
    way_if.ctrl                 ways,
    lookup_if.ctrl              lk,
    input  dcache_pkg::word_t   rd_data
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {IDLE, EVICT_READ, WRITEBACK, FETCH} state_t;

    state_t              state;
    offset_t             cnt;
    logic [NUM_SETS-1:0] plru;
    word_t               line_buf [WORDS_PER_LINE];
    logic                data_ok_q;

    // plru bit names the way to replace; it only moves on hits, so the
    // victim stays put while a miss is serviced
    assign lk.victim_way = plru[dreq_addr.index];

    assign dresp_addr_ok = (state == IDLE) && dreq_valid && lk.any_hit;
    assign dresp_data_ok = data_ok_q;

    always_comb begin
        ways.index     = dreq_addr.index;
        ways.tag       = dreq_addr.tag;
        ways.offset    = cnt;
        ways.wr_en     = 1'b0;
        ways.wr_way    = lk.hit_way;
        ways.wr_strobe = dreq_strobe;
        ways.wr_data   = dreq_data;
        ways.fill_en   = 1'b0;
        ways.fill_way  = lk.victim_way;
        lk.rd_way      = lk.victim_way;
        case (state)
            IDLE: begin
                if (lk.any_hit) begin
                    ways.offset = dreq_addr.offset;
                    lk.rd_way   = lk.hit_way;
                end else begin
                    // start reading the victim's first word early
                    ways.offset = '0;
                end
                ways.wr_en = dresp_addr_ok && (dreq_strobe != '0);
            end
            EVICT_READ: begin
                ways.offset = cnt + offset_t'(1);
            end
            FETCH: begin
                ways.wr_en     = cresp_ready;
                ways.wr_way    = lk.victim_way;
                ways.wr_strobe = '1;
                ways.wr_data   = cresp_data;
                ways.fill_en   = cresp_ready && cresp_last;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state     <= IDLE;
            cnt       <= '0;
            plru      <= '0;
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= dresp_addr_ok;
            if (dresp_addr_ok) begin
                plru[dreq_addr.index] <= ~lk.hit_way;
            end
            case (state)
                IDLE: begin
                    if (dreq_valid && !lk.any_hit) begin
                        state <= (lk.victim_valid && lk.victim_dirty) ? EVICT_READ : FETCH;
                        cnt   <= '0;
                    end
                end
                EVICT_READ: begin
                    cnt <= cnt + offset_t'(1);
                    if (cnt == '1) begin
                        state <= WRITEBACK;
                    end
                end
                WRITEBACK, FETCH: begin
                    if (cresp_ready) begin
                        cnt <= cnt + offset_t'(1);
                        if (cresp_last) begin
                            state <= (state == WRITEBACK) ? FETCH : IDLE;
                            cnt   <= '0;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // victim words arrive one cycle after their offset
    always_ff @(posedge clk) begin
        if (state == EVICT_READ) begin
            line_buf[cnt] <= rd_data;
        end
    end

    assign creq_valid    = (state == WRITEBACK) || (state == FETCH);
    assign creq_is_write = (state == WRITEBACK);
    assign creq_data     = line_buf[cnt];

    // bursts always start at word zero of the line
    always_comb begin
        creq_addr        = dreq_addr;
        creq_addr.offset = '0;
        creq_addr.align  = '0;
        if (state == WRITEBACK) begin
            creq_addr.tag = lk.victim_tag;
        end
    end

endmodule

// File: dcache.sv
`timescale 1ns/100ps

module dcache (
    input  logic                clk,
    input  logic                resetn,
    input  logic                dreq_valid,
    input  dcache_pkg::addr_t   dreq_addr,
    input  dcache_pkg::strobe_t dreq_strobe,
    input  dcache_pkg::word_t   dreq_data,
    output logic                dresp_addr_ok,
    output logic                dresp_data_ok,
    output dcache_pkg::word_t   dresp_data,
    output logic                creq_valid,
    output logic                creq_is_write,
    output dcache_pkg::addr_t   creq_addr,
    output dcache_pkg::word_t   creq_data,
    input  logic                cresp_ready,
    input  logic                cresp_last,
    input  dcache_pkg::word_t   cresp_data
);
    import dcache_pkg::*;

    way_if    bus ();
    lookup_if lk ();

    cache_ctrl u_ctrl (
        .clk           (clk),
        .resetn        (resetn),
        .dreq_valid    (dreq_valid),
        .dreq_addr     (dreq_addr),
        .dreq_strobe   (dreq_strobe),
        .dreq_data     (dreq_data),
        .dresp_addr_ok (dresp_addr_ok),
        .dresp_data_ok (dresp_data_ok),
        .creq_valid    (creq_valid),
        .creq_is_write (creq_is_write),
        .creq_addr     (creq_addr),
        .creq_data     (creq_data),
        .cresp_ready   (cresp_ready),
        .cresp_last    (cresp_last),
        .cresp_data    (cresp_data),
        .ways          (bus),
        .lk            (lk),
        .rd_data       (dresp_data)
    );

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        cache_way #(
            .WAY_ID (w)
        ) u_way (
            .clk    (clk),
            .resetn (resetn),
            .bus    (bus)
        );
    end

    way_select u_sel (
        .clk     (clk),
        .resetn  (resetn),
        .ways    (bus),
        .lk      (lk),
        .rd_data (dresp_data)
    );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic resetn
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset high for the first 8 cycles
    initial begin
        resetn = 1'b1;
        repeat (8) @(posedge clk);
        resetn <= 1'b0;
    end

endmodule

// File: dcache_properties.sv
`timescale 1ns/100ps

module dcache_properties (
    input logic              clk,
    input logic              resetn,
    input logic              dresp_addr_ok,
    input logic              dresp_data_ok,
    input logic              creq_valid,
    input logic              creq_is_write,
    input dcache_pkg::addr_t creq_addr,
    input dcache_pkg::word_t creq_data,
    input logic              cresp_ready,
    input logic              cresp_last
);

    int fail_count = 0;

    // data_ok only ever follows addr_ok
    assert property (@(posedge clk) disable iff (resetn)
        dresp_data_ok |-> $past(dresp_addr_ok))
        else begin
            $error("data_ok without addr_ok in the previous cycle");
            fail_count++;
        end

    // request held until the last beat is taken
    assert property (@(posedge clk) disable iff (resetn)
        creq_valid && !(cresp_ready && cresp_last)
        |=> creq_valid && $stable(creq_addr) && $stable(creq_is_write))
        else begin
            $error("memory request changed inside a burst");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (resetn)
        creq_valid && creq_is_write && !cresp_ready |=> $stable(creq_data))
        else begin
            $error("write data changed while stalled");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (resetn)
        !(dresp_addr_ok && creq_valid))
        else begin
            $error("addr_ok during a memory burst");
            fail_count++;
        end

    assert property (@(posedge clk)
        resetn |=> !dresp_addr_ok && !creq_valid)
        else begin
            $error("handshake high during reset");
            fail_count++;
        end

endmodule

bind dcache dcache_properties u_props (
    .clk           (clk),
    .resetn        (resetn),
    .dresp_addr_ok (dresp_addr_ok),
    .dresp_data_ok (dresp_data_ok),
    .creq_valid    (creq_valid),
    .creq_is_write (creq_is_write),
    .creq_addr     (creq_addr),
    .creq_data     (creq_data),
    .cresp_ready   (cresp_ready),
    .cresp_last    (cresp_last)
);

// File: dcache_tb.sv
`timescale 1ns/100ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int MEM_WORDS  = 16384;
    localparam int NUM_TESTS  = 9;
    localparam int WAIT_LIMIT = 400;

    logic    clk;
    logic    resetn;
    logic    dreq_valid;
    addr_t   dreq_addr;
    strobe_t dreq_strobe;
    word_t   dreq_data;
    logic    dresp_addr_ok;
    logic    dresp_data_ok;
    word_t   dresp_data;
    logic    creq_valid;
    logic    creq_is_write;
    addr_t   creq_addr;
    word_t   creq_data;
    logic    cresp_ready;
    logic    cresp_last;
    word_t   cresp_data;

    word_t   mem [MEM_WORDS];
    integer  seed = 32'h49e206cb;
    logic    stalls;
    logic    in_burst;
    int      beat;
    int      base;
    logic    burst_wr [$];
    addr_t   burst_addr [$];
    int      errors;
    int      tests_done;

    tb_clock_gen u_clk (
        .clk    (clk),
        .resetn (resetn)
    );

    dcache u_dut (
        .clk           (clk),
        .resetn        (resetn),
        .dreq_valid    (dreq_valid),
        .dreq_addr     (dreq_addr),
        .dreq_strobe   (dreq_strobe),
        .dreq_data     (dreq_data),
        .dresp_addr_ok (dresp_addr_ok),
        .dresp_data_ok (dresp_data_ok),
        .dresp_data    (dresp_data),
        .creq_valid    (creq_valid),
        .creq_is_write (creq_is_write),
        .creq_addr     (creq_addr),
        .creq_data     (creq_data),
        .cresp_ready   (cresp_ready),
        .cresp_last    (cresp_last),
        .cresp_data    (cresp_data)
    );

    // memory word rule: byte address xor a5a5a5a5
    function automatic word_t init_word(input word_t byte_addr);
        return {byte_addr[31:2], 2'b00} ^ 32'ha5a5a5a5;
    endfunction

    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                          input strobe_t s);
        word_t m;
        m = old_w;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                m[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return m;
    endfunction

    function automatic addr_t make_addr(input int tag, input int set, input int offset);
        addr_t a;
        a.tag    = tag_t'(tag);
        a.index  = index_t'(set);
        a.offset = offset_t'(offset);
        a.align  = '0;
        return a;
    endfunction

    function automatic addr_t line_of(input addr_t a);
        addr_t l;
        l = a;
        l.offset = '0;
        return l;
    endfunction

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = init_word(word_t'(i * 4));
        end
        cresp_ready = 1'b0;
        cresp_last  = 1'b0;
        cresp_data  = '0;
    end

    // burst memory model, ready drops at random when stalls are on
    always @(posedge clk) begin
        if (resetn) begin
            cresp_ready <= 1'b0;
            cresp_last  <= 1'b0;
            in_burst = 1'b0;
        end else begin
            if (in_burst && cresp_ready) begin
                if (creq_is_write) begin
                    mem[(base + beat) % MEM_WORDS] = creq_data;
                end
                beat = beat + 1;
                in_burst = (beat < WORDS_PER_LINE);
            end else if (!in_burst && creq_valid) begin
                in_burst = 1'b1;
                beat = 0;
                base = int'(creq_addr[15:2]);
                burst_wr.push_back(creq_is_write);
                burst_addr.push_back(creq_addr);
            end
            cresp_ready <= in_burst && (!stalls || ($random(seed) % 3 != 0));
            cresp_last  <= in_burst && (beat == WORDS_PER_LINE - 1);
            cresp_data  <= mem[(base + beat) % MEM_WORDS];
        end
    end

    task automatic compare_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("error %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic clear_bursts();
        burst_wr.delete();
        burst_addr.delete();
    endtask

    task automatic expect_burst_count(input string name, input int count);
        if (burst_addr.size() != count) begin
            $display("error %s: expected %0d bursts, actual %0d", name, count,
                     burst_addr.size());
            errors++;
        end
    endtask

    task automatic verify_burst(input string name, input int i, input logic wr, input addr_t a);
        if (i < burst_addr.size()) begin
            compare_word({name, " burst addr"}, a, burst_addr[i]);
            if (burst_wr[i] !== wr) begin
                $display("error %s burst dir: expected %0b, actual %0b", name, wr, burst_wr[i]);
                errors++;
            end
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_done++;
        if (errors == err_before) begin
            $display("%s%s: ok", name, stalls ? " with stalls" : "");
        end else begin
            $display("%s%s: %0d errors", name, stalls ? " with stalls" : "",
                     errors - err_before);
        end
    endtask

    // one request, started right after a rising edge
    task automatic access(input string name, input addr_t a, input strobe_t s, input word_t d,
                          output word_t rdata);
        int n;
        n = 0;
        rdata = '0;
        dreq_valid  <= 1'b1;
        dreq_addr   <= a;
        dreq_strobe <= s;
        dreq_data   <= d;
        @(posedge clk);
        while (!dresp_addr_ok && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        dreq_valid <= 1'b0;
        if (!dresp_addr_ok) begin
            $display("%s: no addr_ok within %0d cycles", name, WAIT_LIMIT);
            errors++;
        end else begin
            @(posedge clk);
            if (dresp_data_ok !== 1'b1) begin
                $display("%s: data_ok missing one cycle after addr_ok", name);
                errors++;
            end
            rdata = dresp_data;
        end
    endtask

    task automatic reset_outputs_low();
        int e;
        e = errors;
        @(posedge clk);
        while (resetn) begin
            @(posedge clk);
            if (dresp_addr_ok !== 1'b0 || dresp_data_ok !== 1'b0 || creq_valid !== 1'b0) begin
                $display("reset_outputs_low: handshake outputs not low during reset");
                errors++;
            end
        end
        repeat (2) begin
            @(posedge clk);
            if (dresp_addr_ok !== 1'b0 || dresp_data_ok !== 1'b0 || creq_valid !== 1'b0) begin
                $display("reset_outputs_low: handshake outputs not low after reset");
                errors++;
            end
        end
        report_test("reset_outputs_low", e);
    endtask

    task automatic cold_read_miss(input int set);
        addr_t a;
        word_t r;
        int    e;
        e = errors;
        a = make_addr(1, set, 3);
        clear_bursts();
        access("cold_read_miss", a, '0, '0, r);
        compare_word("cold_read_miss data", init_word(a), r);
        expect_burst_count("cold_read_miss", 1);
        verify_burst("cold_read_miss", 0, 1'b0, line_of(a));
        // same line again, no memory traffic
        clear_bursts();
        a.offset = 4'd12;
        access("cold_read_miss", a, '0, '0, r);
        compare_word("cold_read_miss second read", init_word(a), r);
        expect_burst_count("cold_read_miss second read", 0);
        report_test("cold_read_miss", e);
    endtask

    task automatic write_hit_merge(input int set);
        addr_t a;
        word_t r;
        int    e;
        e = errors;
        a = make_addr(2, set, 7);
        access("write_hit_merge", a, '0, '0, r);
        clear_bursts();
        access("write_hit_merge", a, 4'b0101, 32'h1234_5678, r);
        access("write_hit_merge", a, '0, '0, r);
        compare_word("write_hit_merge data",
                     merge_bytes(init_word(a), 32'h1234_5678, 4'b0101), r);
        expect_burst_count("write_hit_merge", 0);
        report_test("write_hit_merge", e);
    endtask

    task automatic plru_replacement(input int set);
        addr_t a;
        addr_t b;
        addr_t c;
        word_t r;
        int    e;
        e = errors;
        a = make_addr(3, set, 1);
        b = make_addr(4, set, 1);
        c = make_addr(5, set, 1);
        access("plru_replacement", a, '0, '0, r);
        access("plru_replacement", b, '0, '0, r);
        access("plru_replacement", a, '0, '0, r);
        access("plru_replacement", c, '0, '0, r);
        compare_word("plru_replacement line c", init_word(c), r);
        clear_bursts();
        access("plru_replacement", a, '0, '0, r);
        compare_word("plru_replacement line a", init_word(a), r);
        expect_burst_count("plru_replacement line a", 0);
        // b was the least recently used line
        clear_bursts();
        access("plru_replacement", b, '0, '0, r);
        compare_word("plru_replacement line b", init_word(b), r);
        expect_burst_count("plru_replacement line b", 1);
        verify_burst("plru_replacement line b", 0, 1'b0, line_of(b));
        report_test("plru_replacement", e);
    endtask

    task automatic dirty_writeback(input int set);
        addr_t a;
        addr_t d;
        addr_t x;
        word_t r;
        word_t merged;
        int    e;
        e = errors;
        a = make_addr(6, set, 2);
        d = make_addr(7, set, 0);
        x = make_addr(8, set, 0);
        merged = merge_bytes(init_word(a), 32'hdead_beef, 4'b1100);
        access("dirty_writeback", a, '0, '0, r);
        access("dirty_writeback", a, 4'b1100, 32'hdead_beef, r);
        access("dirty_writeback", d, '0, '0, r);
        clear_bursts();
        access("dirty_writeback", x, '0, '0, r);
        compare_word("dirty_writeback new line", init_word(x), r);
        expect_burst_count("dirty_writeback eviction", 2);
        verify_burst("dirty_writeback eviction", 0, 1'b1, line_of(a));
        verify_burst("dirty_writeback eviction", 1, 1'b0, line_of(x));
        compare_word("dirty_writeback memory", merged, mem[a[15:2]]);
        clear_bursts();
        access("dirty_writeback", a, '0, '0, r);
        compare_word("dirty_writeback reread", merged, r);
        expect_burst_count("dirty_writeback reread", 1);
        report_test("dirty_writeback", e);
    endtask

    // watchdog sized from the test count
    initial begin
        #(NUM_TESTS * 2000 * 40);
        $display("watchdog: simulation did not finish in time");
        $display("Test failed");
        $finish;
    end

    initial begin
        dreq_valid  = 1'b0;
        dreq_addr   = '0;
        dreq_strobe = '0;
        dreq_data   = '0;
        stalls      = 1'b0;
        errors      = 0;
        tests_done  = 0;
        reset_outputs_low();
        cold_read_miss(1);
        write_hit_merge(2);
        plru_replacement(3);
        dirty_writeback(4);
        stalls = 1'b1;
        cold_read_miss(17);
        write_hit_merge(18);
        plru_replacement(19);
        dirty_writeback(20);
        if (u_dut.u_props.fail_count != 0) begin
            $display("%0d property assertions failed", u_dut.u_props.fail_count);
            errors += u_dut.u_props.fail_count;
        end
        $display("%0d tests run, %0d errors", tests_done, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: dcache.f
dcache_pkg.sv
cache_ifs.sv
cache_way.sv
way_select.sv
cache_ctrl.sv
dcache.sv
tb_clock_gen.sv
dcache_properties.sv
dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - dcache_pkg.sv
  - cache_ifs.sv
  - cache_way.sv
  - way_select.sv
  - cache_ctrl.sv
  - dcache.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - dcache_properties.sv
      - dcache_tb.sv
